// ==== motor_config.svh ====
/* widths, timing and regulator constants for the motor speed channel
   included by the package and by every RTL file that sizes a signal */

`ifndef MOTOR_CONFIG_SVH
`define MOTOR_CONFIG_SVH

// ==================================================
// data path widths
// ==================================================
`define MC_COUNT_W          32      // signed encoder position
`define MC_SPEED_W          16      // speed and error, counts per window
`define MC_GAIN_W           17      // each of kp, ki, kd
`define MC_DUTY_W           8       // pwm period is 2**MC_DUTY_W cycles

// ==================================================
// timing
// ==================================================
`define MC_DEBOUNCE_CYCLES  8       // stable cycles before a line is accepted
`define MC_SAMPLE_CYCLES    250000  // 5 ms at 50 MHz

// ==================================================
// regulator
// ==================================================
// pid sum is scaled down by this shift before it becomes duty
`define MC_GAIN_SHIFT       8
`define MC_INTEG_LIMIT      4095    // symmetric integral clamp

`endif

// ==== motor_pkg.sv ====
/* struct types shared by the motor channel RTL and its testbench
   compile before any module that names motor_pkg */

`default_nettype none

`include "motor_config.svh"

package motor_pkg;

	// encoder line pair, a is the msb
	typedef struct packed {
		logic a;
		logic b;
	} quad_t;

	// host command as it arrives on the req/ack port
	typedef struct packed {
		logic [7:0]            rpm;  // unsigned magnitude
		logic [1:0]            dir;  // 01 fwd, 11 rev, else stop
		logic [`MC_GAIN_W-1:0] kp;
		logic [`MC_GAIN_W-1:0] ki;
		logic [`MC_GAIN_W-1:0] kd;
	} ctrl_cmd_t;

	// captured command in the form the regulator uses
	typedef struct packed {
		logic signed [`MC_SPEED_W-1:0] setpoint;
		logic [`MC_GAIN_W-1:0]         kp;
		logic [`MC_GAIN_W-1:0]         ki;
		logic [`MC_GAIN_W-1:0]         kd;
	} ctrl_set_t;

	// bridge drive, duty plus direction pins
	typedef struct packed {
		logic [`MC_DUTY_W-1:0] duty;
		logic                  fwd;
		logic                  rev;
	} drive_t;

endpackage

`default_nettype wire

// ==== quad_debounce.sv ====
/* two-flop synchronizer and stability filter for the encoder a/b pair
   the pair is filtered as one value so a and b never skew */

`default_nettype none
`timescale 1ns/1ps

`include "motor_config.svh"

module quad_debounce
(
	input  wire             fpga_clk_50,
	input  wire             hps_fpga_reset_n,
	input  motor_pkg::quad_t enc,        // raw pins
	output motor_pkg::quad_t enc_clean   // filtered pair
);
	import motor_pkg::*;

	localparam int DEB = `MC_DEBOUNCE_CYCLES;
	localparam int CW  = $clog2(DEB + 1);

	quad_t           sync_1, sync_2;   // metastability chain
	quad_t           sample_q;         // last raw sample
	logic [CW-1:0]   stable_cnt;       // cycles since last change

	// ==================================================
	// sync, stability count, output update
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			sync_1     <= '0;
			sync_2     <= '0;
			sample_q   <= '0;
			stable_cnt <= '0;
			enc_clean  <= '0;
		end
		else
		begin
			sync_1   <= enc;
			sync_2   <= sync_1;
			sample_q <= sync_2;
			if (sync_2 != sample_q)
				stable_cnt <= '0;                  // any edge restarts
			else if (stable_cnt != CW'(DEB))
				stable_cnt <= stable_cnt + 1'b1;   // saturates at DEB
			if (stable_cnt == CW'(DEB))
				enc_clean <= sample_q;             // held long enough
		end
	end

endmodule

`default_nettype wire

// ==== quad_decoder.sv ====
/* x4 quadrature decoder on the debounced pair
   one count per gray step, sign from the step direction */

`default_nettype none
`timescale 1ns/1ps

`include "motor_config.svh"

module quad_decoder
(
	input  wire                             fpga_clk_50,
	input  wire                             hps_fpga_reset_n,
	input  motor_pkg::quad_t                enc_clean,
	output logic signed [`MC_COUNT_W-1:0]   count
);
	import motor_pkg::*;

	quad_t      prev;       // pair seen last cycle
	logic [3:0] step;       // {prev, current}
	logic       inc, dec;

	assign step = {prev, enc_clean};

	// gray step table
	// forward is 00 -> 01 -> 11 -> 10 -> 00
	always_comb
	begin
		inc = 1'b0;
		dec = 1'b0;
		case (step)
			4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00:
				inc = 1'b1;
			4'b01_00, 4'b11_01, 4'b10_11, 4'b00_10:
				dec = 1'b1;
			default:
				;                   // no move or double jump
		endcase
	end

	// ==================================================
	// position register
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			prev  <= '0;
			count <= '0;
		end
		else
		begin
			prev <= enc_clean;
			if (inc)
				count <= count + 1'b1;
			else if (dec)
				count <= count - 1'b1;   // wraps, host sees signed
		end
	end

endmodule

`default_nettype wire

// ==== speed_meter.sv ====
/* sample period timer and position difference per window
   speed is in encoder counts per sample period, sample_valid marks each update */

`default_nettype none
`timescale 1ns/1ps

`include "motor_config.svh"

module speed_meter
(
	input  wire                             fpga_clk_50,
	input  wire                             hps_fpga_reset_n,
	input  wire signed [`MC_COUNT_W-1:0]    count,
	output logic signed [`MC_SPEED_W-1:0]   speed,
	output logic                            sample_valid
);
	localparam int PERIOD = `MC_SAMPLE_CYCLES;
	localparam int PW     = $clog2(PERIOD);

	logic [PW-1:0]                  tick;      // period counter
	logic                           strobe;
	logic signed [`MC_COUNT_W-1:0]  snap;      // count at last strobe
	logic signed [`MC_COUNT_W-1:0]  delta;

	assign strobe = (tick == PW'(PERIOD - 1));
	assign delta  = count - snap;              // wraps cleanly on overflow

	// ==================================================
	// timer and window difference
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			tick         <= '0;
			snap         <= '0;
			speed        <= '0;
			sample_valid <= 1'b0;
		end
		else
		begin
			sample_valid <= strobe;   // lines up with the speed update
			if (strobe)
			begin
				tick  <= '0;
				snap  <= count;
				// keep low bits only
				speed <= delta[`MC_SPEED_W-1:0];
			end
			else
			begin
				tick <= tick + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cmd_port.sv ====
/* four-phase req/ack receiver for setpoint and gains
   host holds cmd with req high until ack, then drops req and waits for ack low */

`default_nettype none
`timescale 1ns/1ps

`include "motor_config.svh"

module cmd_port
(
	input  wire                   fpga_clk_50,
	input  wire                   hps_fpga_reset_n,
	input  wire                   cmd_req,
	input  motor_pkg::ctrl_cmd_t  cmd,
	output logic                  cmd_ack,
	output motor_pkg::ctrl_set_t  set
);
	import motor_pkg::*;

	localparam logic [1:0] DIR_FWD = 2'b01;
	localparam logic [1:0] DIR_REV = 2'b11;

	logic                          req_s1, req_s2;   // req synchronizer
	logic signed [`MC_SPEED_W-1:0] rpm_ext;
	ctrl_set_t                     set_n;

	// rpm is unsigned, zero extend before the sign is applied
	assign rpm_ext = $signed({{(`MC_SPEED_W - $bits(cmd.rpm)){1'b0}}, cmd.rpm});

	always_comb
	begin
		set_n.kp = cmd.kp;
		set_n.ki = cmd.ki;
		set_n.kd = cmd.kd;
		case (cmd.dir)
			DIR_FWD: set_n.setpoint = rpm_ext;
			DIR_REV: set_n.setpoint = -rpm_ext;
			default: set_n.setpoint = '0;     // 00 and 10 stop
		endcase
	end

	// ==================================================
	// handshake, ack follows synchronized req
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			req_s1  <= 1'b0;
			req_s2  <= 1'b0;
			cmd_ack <= 1'b0;
			set     <= '0;
		end
		else
		begin
			req_s1  <= cmd_req;
			req_s2  <= req_s1;
			cmd_ack <= req_s2;
			if (req_s2 && !cmd_ack)
				set <= set_n;                 // capture once per request
		end
	end

endmodule

`default_nettype wire

// ==== pid_regulator.sv ====
/* discrete PID speed regulator, one step per sample_valid
   output is a duty magnitude and a direction pair for the bridge */

`default_nettype none
`timescale 1ns/1ps

`include "motor_config.svh"

module pid_regulator
(
	input  wire                             fpga_clk_50,
	input  wire                             hps_fpga_reset_n,
	input  motor_pkg::ctrl_set_t            set,
	input  wire signed [`MC_SPEED_W-1:0]    speed,
	input  wire                             sample_valid,
	output motor_pkg::drive_t               drive
);
	import motor_pkg::*;

	localparam int SW       = `MC_SPEED_W;
	localparam int ACC_W    = `MC_GAIN_W + SW + 4;          // room for three products
	localparam int LIM      = `MC_INTEG_LIMIT;
	localparam int DUTY_MAX = (1 << `MC_DUTY_W) - 1;

	// state across samples
	logic signed [SW-1:0]     integ;
	logic signed [SW-1:0]     err_q;

	// next step values
	logic signed [SW-1:0]     err_n;
	logic signed [SW:0]       integ_sum;
	logic signed [SW-1:0]     integ_n;
	logic signed [SW:0]       deriv_n;
	logic signed [ACC_W-1:0]  acc;
	logic signed [ACC_W-1:0]  u;
	logic [ACC_W-1:0]         u_mag;
	drive_t                   drive_n;

	// ==================================================
	// control law
	// ==================================================
	always_comb
	begin
		err_n     = $signed(set.setpoint) - speed;      // error kept at speed width
		integ_sum = integ + err_n;
		if (integ_sum > LIM)
			integ_n = SW'(LIM);
		else if (integ_sum < -LIM)
			integ_n = -SW'(LIM);
		else
			integ_n = integ_sum[SW-1:0];
		deriv_n   = err_n - err_q;

		// gains are unsigned, force a zero sign bit
		acc = $signed({1'b0, set.kp}) * err_n
			+ $signed({1'b0, set.ki}) * integ_n
			+ $signed({1'b0, set.kd}) * deriv_n;
		u   = acc >>> `MC_GAIN_SHIFT;

		u_mag = u[ACC_W-1] ? -u : u;
		if (u_mag > ACC_W'(DUTY_MAX))
			drive_n.duty = `MC_DUTY_W'(DUTY_MAX);        // saturate
		else
			drive_n.duty = u_mag[`MC_DUTY_W-1:0];
		drive_n.fwd = !u[ACC_W-1] && (u != '0);
		drive_n.rev = u[ACC_W-1];
	end

	// ==================================================
	// sample registers
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			integ <= '0;
			err_q <= '0;
			drive <= '0;
		end
		else if (sample_valid)
		begin
			integ <= integ_n;
			err_q <= err_n;
			drive <= drive_n;     // one cycle after the strobe
		end
	end

endmodule

`default_nettype wire

// ==== pwm_driver.sv ====
/* fixed period PWM generator, period 2**MC_DUTY_W cycles
   duty is sampled only at the period start so each period is clean */

`default_nettype none
`timescale 1ns/1ps

`include "motor_config.svh"

module pwm_driver
(
	input  wire                fpga_clk_50,
	input  wire                hps_fpga_reset_n,
	input  motor_pkg::drive_t  drive,
	output logic               pwm
);
	logic [`MC_DUTY_W-1:0] cnt;        // free running
	logic [`MC_DUTY_W-1:0] duty_q;     // duty for current period
	logic                  wrap;

	assign wrap = &cnt;                // last cycle of the period

	// ==================================================
	// counter, duty latch, output flop
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			cnt    <= '0;
			duty_q <= '0;
			pwm    <= 1'b0;
		end
		else
		begin
			cnt <= cnt + 1'b1;
			if (wrap)
				duty_q <= drive.duty;   // new value as cnt goes to 0
			pwm <= (cnt < duty_q);      // duty high cycles per period, 0 stays low
		end
	end

endmodule

`default_nettype wire

// ==== motor_channel.sv ====
/* one closed loop motor channel
   encoder in, host command port in, pwm and direction pins plus status out */

`default_nettype none
`timescale 1ns/1ps

`include "motor_config.svh"

module motor_channel
(
	input  wire                             fpga_clk_50,
	input  wire                             hps_fpga_reset_n,
	input  motor_pkg::quad_t                enc,
	input  wire                             cmd_req,
	input  motor_pkg::ctrl_cmd_t            cmd,
	output logic                            cmd_ack,
	output logic signed [`MC_COUNT_W-1:0]   count,
	output logic signed [`MC_SPEED_W-1:0]   speed,
	output logic [`MC_DUTY_W-1:0]           duty,
	output logic                            fwd,
	output logic                            rev,
	output logic                            pwm
);
	import motor_pkg::*;

	quad_t      enc_clean;
	logic       sample_valid;     // one cycle per window
	ctrl_set_t  set;
	drive_t     drive;

	// status and bridge direction pins
	assign duty = drive.duty;
	assign fwd  = drive.fwd;
	assign rev  = drive.rev;

	// ==================================================
	// measurement path
	// ==================================================
	quad_debounce u_quad_debounce (
		.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
		.enc (enc), .enc_clean (enc_clean)
	);
	quad_decoder u_quad_decoder (
		.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
		.enc_clean (enc_clean), .count (count)
	);
	speed_meter u_speed_meter (
		.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
		.count (count), .speed (speed), .sample_valid (sample_valid)
	);

	// ==================================================
	// command, regulator, output stage
	// ==================================================
	cmd_port u_cmd_port (
		.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
		.cmd_req (cmd_req), .cmd (cmd), .cmd_ack (cmd_ack), .set (set)
	);
	pid_regulator u_pid_regulator (
		.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
		.set (set), .speed (speed), .sample_valid (sample_valid), .drive (drive)
	);
	pwm_driver u_pwm_driver (
		.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
		.drive (drive), .pwm (pwm)
	);

endmodule

`default_nettype wire

// ==== tb_motor_channel.sv ====
/* testbench for one motor channel driving encoder steps and host commands
   checks position, window speed, regulator drive and pwm against reference models */

`default_nettype none
`timescale 1ns/1ps

`include "motor_config.svh"

module tb_motor_channel;
	import motor_pkg::*;

	localparam int PERIOD     = `MC_SAMPLE_CYCLES;
	localparam int HOLD       = 20;                       // cycles per gray state
	localparam int GLITCH     = `MC_DEBOUNCE_CYCLES / 2;  // too short to pass the filter
	localparam int HS_LIMIT   = 32;                       // handshake timeout in cycles
	localparam int WAIT_LIMIT = 2 * PERIOD;

	// dut pins
	logic                            fpga_clk_50;
	logic                            hps_fpga_reset_n;
	quad_t                           enc;
	logic                            cmd_req;
	ctrl_cmd_t                       cmd;
	logic                            cmd_ack;
	logic signed [`MC_COUNT_W-1:0]   count;
	logic signed [`MC_SPEED_W-1:0]   speed;
	logic [`MC_DUTY_W-1:0]           duty;
	logic                            fwd, rev, pwm;

	// model state
	int                              cyc = 0;          // cycles since reset release
	int                              checks = 0;
	int                              errors = 0;
	int                              exp_pos = 0;      // steps issued so far
	int                              snap_pos = 0;     // exp_pos at last window
	int                              seen_speed = 0;
	int                              cur_sp = 0;
	int                              cur_kp = 0;
	int                              cur_ki = 0;
	int                              cur_kd = 0;
	int                              integ_m = 0;      // regulator integral
	int                              prev_err_m = 0;
	int                              enc_idx = 0;      // position in gray cycle
	logic signed [`MC_SPEED_W-1:0]   exp_spd;
	drive_t                          exp_drv;
	drive_t                          last_drv = '0;
	integer                          seed;
	logic [1:0]                      gray_seq [0:3] = '{2'b00, 2'b01, 2'b11, 2'b10};

	motor_channel u_motor_channel (
		.fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
		.enc (enc), .cmd_req (cmd_req), .cmd (cmd), .cmd_ack (cmd_ack),
		.count (count), .speed (speed), .duty (duty),
		.fwd (fwd), .rev (rev), .pwm (pwm)
	);

	initial
	begin
		fpga_clk_50 = 1'b0;
		forever #10 fpga_clk_50 = ~fpga_clk_50;   // 50 MHz
	end

	always @(posedge fpga_clk_50)
	begin
		if (hps_fpga_reset_n)
			cyc <= cyc + 1;    // tracks the dut sample timer
	end

	// ==================================================
	// reference models
	// ==================================================
	function automatic int exp_setpoint(input int rpm, input logic [1:0] dir);
		if (dir == 2'b01)
			return rpm;
		else if (dir == 2'b11)
			return -rpm;
		return 0;                               // 00 and 10 stop
	endfunction

	// one regulator step with its own integral and last error
	function automatic drive_t exp_drive(input int sp, input int spd,
		input int kp, input int ki, input int kd);
		longint e, isum, d, acc, u, mag;
		drive_t r;
		e    = sp - spd;
		isum = integ_m + e;
		if (isum > `MC_INTEG_LIMIT)
			isum = `MC_INTEG_LIMIT;
		else if (isum < -`MC_INTEG_LIMIT)
			isum = -`MC_INTEG_LIMIT;
		d    = e - prev_err_m;
		acc  = kp * e + ki * isum + kd * d;
		u    = acc >>> `MC_GAIN_SHIFT;          // rounds toward minus infinity
		mag  = (u < 0) ? -u : u;
		r.duty = (mag > 255) ? 8'hff : 8'(mag);
		r.fwd  = (u > 0);
		r.rev  = (u < 0);
		integ_m    = int'(isum);
		prev_err_m = int'(e);
		return r;
	endfunction

	function automatic int exp_high_cycles(input int d);
		return d;          // counter < duty over 256 counts
	endfunction

	function automatic ctrl_cmd_t make_cmd(input int rpm, input logic [1:0] dir,
		input int kp, input int ki, input int kd);
		ctrl_cmd_t c;
		c.rpm = 8'(rpm);
		c.dir = dir;
		c.kp  = `MC_GAIN_W'(kp);
		c.ki  = `MC_GAIN_W'(ki);
		c.kd  = `MC_GAIN_W'(kd);
		return c;
	endfunction

	// ==================================================
	// checking and reporting
	// ==================================================
	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_and_finish();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	// speed checked at each window end and drive one cycle later
	always @(negedge fpga_clk_50)
	begin
		if (hps_fpga_reset_n && cyc > 0 && (cyc % PERIOD) == 0)
		begin
			exp_spd = exp_pos - snap_pos;
			check_value("speed", speed, exp_spd);
			snap_pos   = exp_pos;
			seen_speed = speed;
		end
		if (hps_fpga_reset_n && cyc > 1 && (cyc % PERIOD) == 1)
		begin
			exp_drv = exp_drive(cur_sp, seen_speed, cur_kp, cur_ki, cur_kd);
			check_value("duty", duty, exp_drv.duty);
			check_value("fwd", fwd, exp_drv.fwd);
			check_value("rev", rev, exp_drv.rev);
			last_drv = exp_drv;
		end
	end

	// ==================================================
	// stimulus tasks
	// ==================================================
	task automatic wait_cycle(input int target);
		int n;
		n = 0;
		while (cyc < target && n < WAIT_LIMIT)
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		if (cyc < target)
		begin
			errors++;
			$display("timeout waiting for sample window at cycle %0d", target);
			report_and_finish();
		end
	endtask

	// req up then ack up then req down then ack down
	task automatic send_cmd(input ctrl_cmd_t c);
		int n;
		@(posedge fpga_clk_50);
		#1;
		cmd     = c;
		cmd_req = 1'b1;
		n = 0;
		while (!cmd_ack && n < HS_LIMIT)
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		if (!cmd_ack)
		begin
			errors++;
			$display("timeout, cmd_ack did not rise after cmd_req");
			report_and_finish();
		end
		@(posedge fpga_clk_50);
		#1;
		cmd_req = 1'b0;
		n = 0;
		while (cmd_ack && n < HS_LIMIT)
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		if (cmd_ack)
		begin
			errors++;
			$display("timeout, cmd_ack did not fall after cmd_req dropped");
			report_and_finish();
		end
		cur_sp = exp_setpoint(c.rpm, c.dir);
		cur_kp = c.kp;
		cur_ki = c.ki;
		cur_kd = c.kd;
	endtask

	task automatic step_enc(input bit forward, input int n);
		repeat (n)
		begin
			@(posedge fpga_clk_50);
			#1;
			enc_idx = forward ? (enc_idx + 1) % 4 : (enc_idx + 3) % 4;
			enc     = gray_seq[enc_idx];
			exp_pos = forward ? exp_pos + 1 : exp_pos - 1;
			repeat (HOLD) @(posedge fpga_clk_50);
		end
	endtask

	// short pulse on a (sel 0) or b (sel 1) and back
	// count must hold through the pulse and the settle time after it
	task automatic glitch_line(input bit sel);
		@(posedge fpga_clk_50);
		#1;
		if (sel)
			enc.b = ~enc.b;
		else
			enc.a = ~enc.a;
		repeat (GLITCH)
		begin
			@(negedge fpga_clk_50);
			check_value("count", count, exp_pos);
			@(posedge fpga_clk_50);
		end
		#1;
		enc = gray_seq[enc_idx];
		repeat (HOLD)
		begin
			@(negedge fpga_clk_50);
			check_value("count", count, exp_pos);
		end
	endtask

	task automatic measure_pwm();
		int high;
		high = 0;
		repeat (2 * 256 + 4) @(posedge fpga_clk_50);   // duty latched by now
		repeat (256)
		begin
			@(negedge fpga_clk_50);
			if (pwm)
				high++;
		end
		check_value("pwm_high", high, exp_high_cycles(last_drv.duty));
	endtask

	// ==================================================
	// main sequence with one scenario per sample window
	// ==================================================
	initial
	begin
		int n_fwd, n_rev, n;
		bit d;
		seed             = 32'hef37;
		hps_fpga_reset_n = 1'b0;
		enc              = '0;
		cmd_req          = 1'b0;
		cmd              = '0;
		repeat (4) @(posedge fpga_clk_50);
		#1;
		hps_fpga_reset_n = 1'b1;
		@(negedge fpga_clk_50);
		check_value("cmd_ack", cmd_ack, 0);
		check_value("pwm", pwm, 0);
		check_value("fwd", fwd, 0);
		check_value("rev", rev, 0);
		check_value("duty", duty, 0);
		check_value("count", count, 0);
		check_value("speed", speed, 0);

		// back to back commands then position
		send_cmd(make_cmd(0, 2'b00, 0, 0, 0));
		send_cmd(make_cmd(40, 2'b01, 512, 32, 128));
		n_fwd = 8 + ($unsigned($random(seed)) % 16);
		n_rev = $unsigned($random(seed)) % 8;
		step_enc(1'b1, n_fwd);
		step_enc(1'b0, n_rev);
		@(negedge fpga_clk_50);
		check_value("count", count, n_fwd - n_rev);
		glitch_line(1'b0);
		glitch_line(1'b1);
		@(negedge fpga_clk_50);
		check_value("count", count, n_fwd - n_rev);   // glitches filtered

		// random mix where speed is the net step count
		wait_cycle(PERIOD + 10);
		measure_pwm();
		repeat (12)
		begin
			d = $random(seed) & 1;
			n = 1 + ($unsigned($random(seed)) % 5);
			step_enc(d, n);
		end

		// reverse setpoint
		wait_cycle(2 * PERIOD + 10);
		measure_pwm();
		send_cmd(make_cmd(60, 2'b11, 512, 32, 128));
		step_enc(1'b0, 20);
		@(negedge fpga_clk_50);
		check_value("count", count, exp_pos);

		// stop
		wait_cycle(3 * PERIOD + 10);
		measure_pwm();
		send_cmd(make_cmd(90, 2'b00, 512, 32, 128));

		// large setpoint pins duty at max
		wait_cycle(4 * PERIOD + 10);
		measure_pwm();
		send_cmd(make_cmd(255, 2'b01, 4096, 64, 0));
		step_enc(1'b1, 5);
		wait_cycle(5 * PERIOD + 10);
		check_value("duty_sat", duty, 8'hff);
		measure_pwm();
		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
motor_pkg.sv
quad_debounce.sv
quad_decoder.sv
speed_meter.sv
cmd_port.sv
pid_regulator.sv
pwm_driver.sv
motor_channel.sv
tb_motor_channel.sv
